/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sources.f \
		--top-module exec_backend_tb -o exec_backend_sim
	./obj_dir/exec_backend_sim

clean:
	rm -rf obj_dir

/* source/cdb_arbiter.sv */
// Fixed priority int, mem, mul, div; no back-pressure, so a full queue must never see a push
`timescale 1ns/1ps

module cdb_arbiter import exec_pkg::*; (
	input logic clk,
	input logic rst,
	input unit_result_t int_result,
	input unit_result_t mem_result,
	input unit_result_t mul_result,
	input unit_result_t div_result,
	output cdb_t cdb
);

	localparam int n_src = 4;
	localparam int ptr_w = $clog2(cdb_fifo_depth);

	unit_result_t src [n_src];
	unit_result_t q_mem [n_src][cdb_fifo_depth];
	logic [ptr_w-1:0] wr_ptr [n_src];
	logic [ptr_w-1:0] rd_ptr [n_src];
	logic [ptr_w:0] count [n_src];
	logic [n_src-1:0] push;
	logic [n_src-1:0] pop;
	logic [n_src-1:0] full;
	logic [1:0] sel;

	// Index order is the priority order
	always_comb begin
		src[0] = int_result;
		src[1] = mem_result;
		src[2] = mul_result;
		src[3] = div_result;
	end

	always_comb begin
		for (int u = 0; u < n_src; u++) begin
			push[u] = src[u].valid || src[u].branch;
			full[u] = (count[u] == (ptr_w + 1)'(cdb_fifo_depth));
		end
	end

	always_comb begin
		logic found;
		found = 1'b0;
		sel = '0;
		pop = '0;
		for (int u = 0; u < n_src; u++) begin
			if (!found && count[u] != '0) begin
				found = 1'b1;
				sel = 2'(u);
			end
		end
		pop[sel] = found;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cdb <= '0;
			for (int u = 0; u < n_src; u++) begin
				wr_ptr[u] <= '0;
				rd_ptr[u] <= '0;
				count[u] <= '0;
			end
		end else begin
			for (int u = 0; u < n_src; u++) begin
				if (push[u])
					wr_ptr[u] <= wr_ptr[u] + 1'b1;
				if (pop[u])
					rd_ptr[u] <= rd_ptr[u] + 1'b1;
				count[u] <= count[u] + (ptr_w + 1)'(push[u]) - (ptr_w + 1)'(pop[u]);
			end
			cdb <= (|pop) ? q_mem[sel][rd_ptr[sel]] : '0;
		end
	end

	always_ff @(posedge clk) begin
		for (int u = 0; u < n_src; u++)
			if (push[u])
				q_mem[u][wr_ptr[u]] <= src[u];
	end

	// Issue rate upstream is what keeps the queues from filling
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		(push & full) == '0);

	a_cdb_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(cdb.valid && cdb.branch));

endmodule

/* source/exec_backend_top.sv */
// Execution back end; at most one issue per unit per cycle and one every two cycles overall
`timescale 1ns/1ps

module exec_backend_top import exec_pkg::*; (
	input logic clk,
	input logic rst,
	input logic int_issue_valid,
	input alu_issue_t int_issue,
	input logic mul_issue_valid,
	input md_issue_t mul_issue,
	input logic div_issue_valid,
	input md_issue_t div_issue,
	input logic mem_issue_valid,
	input mem_issue_t mem_issue,
	output cdb_t cdb
);

	unit_result_t int_res;
	unit_result_t mul_res;
	unit_result_t div_res;
	unit_result_t mem_res;

	int_alu_unit alu0 (
		.clk(clk),
		.rst(rst),
		.issue_valid(int_issue_valid),
		.issue(int_issue),
		.result(int_res)
	);

	muldiv_pipe #(.op(op_mul)) mul0 (
		.clk(clk),
		.rst(rst),
		.issue_valid(mul_issue_valid),
		.issue(mul_issue),
		.result(mul_res)
	);

	muldiv_pipe #(.op(op_div)) div0 (
		.clk(clk),
		.rst(rst),
		.issue_valid(div_issue_valid),
		.issue(div_issue),
		.result(div_res)
	);

	load_store_unit lsu0 (
		.clk(clk),
		.rst(rst),
		.issue_valid(mem_issue_valid),
		.issue(mem_issue),
		.result(mem_res)
	);

	cdb_arbiter arb0 (
		.clk(clk),
		.rst(rst),
		.int_result(int_res),
		.mem_result(mem_res),
		.mul_result(mul_res),
		.div_result(div_res),
		.cdb(cdb)
	);

endmodule

/* source/exec_pkg.sv */
// Shared back-end types; cdb_fifo_depth must be a power of two, issue payloads come pre-decoded
package exec_pkg;

	localparam int xlen = 32;
	localparam int tag_w = 6;

	// Data memory window
	localparam logic [xlen-1:0] data_base = 32'h1001_0000;
	localparam int dmem_words = 32;

	localparam int cdb_fifo_depth = 4;

	// Issue edge to result entering the arbiter
	localparam int int_latency = 1;
	localparam int mul_latency = 2;
	localparam int div_latency = 3;
	localparam int mem_latency = 4;

	// funct3 and funct7 codes
	localparam logic [2:0] f3_add = 3'h0;
	localparam logic [2:0] f3_xor = 3'h4;
	localparam logic [2:0] f3_or = 3'h6;
	localparam logic [2:0] f3_and = 3'h7;
	localparam logic [2:0] f3_beq = 3'h0;
	localparam logic [2:0] f3_bne = 3'h1;
	localparam logic [6:0] f7_base = 7'h00;
	localparam logic [6:0] f7_sub = 7'h20;

	typedef enum logic [6:0] {
		r_type = 7'h33,
		i_type = 7'h13,
		lui_type = 7'h37,
		branch_type = 7'h63
	} int_opcode_e;

	typedef enum logic {
		op_mul,
		op_div
	} muldiv_op_e;

	// rs2_data holds the formed immediate for I-type and LUI
	typedef struct packed {
		int_opcode_e opcode;
		logic [2:0] funct3;
		logic [6:0] funct7;
		logic [xlen-1:0] rs1_data;
		logic [xlen-1:0] rs2_data;
		logic [tag_w-1:0] rd_tag;
	} alu_issue_t;

	typedef struct packed {
		logic [xlen-1:0] rs1_data;
		logic [xlen-1:0] rs2_data;
		logic [tag_w-1:0] rd_tag;
	} md_issue_t;

	typedef struct packed {
		logic is_store;
		logic [xlen-1:0] rs1_data;
		logic [xlen-1:0] rs2_data;
		logic [xlen-1:0] imm;
		logic [tag_w-1:0] rd_tag;
	} mem_issue_t;

	// Branch outcomes carry tag and data of zero
	typedef struct packed {
		logic valid;
		logic [tag_w-1:0] tag;
		logic [xlen-1:0] data;
		logic branch;
		logic branch_taken;
	} cdb_t;

	typedef cdb_t unit_result_t;

endpackage

/* source/int_alu_unit.sv */
// Integer ALU and BEQ/BNE compare; unknown encodings return data 0, result lives one cycle
`timescale 1ns/1ps

module int_alu_unit import exec_pkg::*; (
	input logic clk,
	input logic rst,
	input logic issue_valid,
	input alu_issue_t issue,
	output unit_result_t result
);

	logic [xlen-1:0] alu_data;
	logic taken;
	logic is_branch;

	assign is_branch = (issue.opcode == branch_type);

	always_comb begin
		alu_data = '0;
		taken = 1'b0;
		case (issue.opcode)
			r_type: begin
				case (issue.funct3)
					f3_add: begin
						if (issue.funct7 == f7_sub)
							alu_data = issue.rs1_data - issue.rs2_data;
						else if (issue.funct7 == f7_base)
							alu_data = issue.rs1_data + issue.rs2_data;
					end
					f3_xor: alu_data = issue.rs1_data ^ issue.rs2_data;
					f3_or: alu_data = issue.rs1_data | issue.rs2_data;
					f3_and: alu_data = issue.rs1_data & issue.rs2_data;
					default: alu_data = '0;
				endcase
			end
			// Immediate already sits in rs2_data
			i_type: begin
				case (issue.funct3)
					f3_add: alu_data = issue.rs1_data + issue.rs2_data;
					f3_xor: alu_data = issue.rs1_data ^ issue.rs2_data;
					f3_or: alu_data = issue.rs1_data | issue.rs2_data;
					f3_and: alu_data = issue.rs1_data & issue.rs2_data;
					default: alu_data = '0;
				endcase
			end
			lui_type: alu_data = issue.rs2_data;
			branch_type: begin
				if (issue.funct3 == f3_beq)
					taken = (issue.rs1_data == issue.rs2_data);
				else if (issue.funct3 == f3_bne)
					taken = (issue.rs1_data != issue.rs2_data);
			end
			default: alu_data = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			result <= '0;
		end else begin
			result.valid <= issue_valid && !is_branch;
			result.tag <= is_branch ? '0 : issue.rd_tag;
			result.data <= is_branch ? '0 : alu_data;
			result.branch <= issue_valid && is_branch;
			result.branch_taken <= issue_valid && is_branch && taken;
		end
	end

	a_known_opcode: assert property (@(posedge clk) disable iff (rst)
		issue_valid |-> issue.opcode inside {r_type, i_type, lui_type, branch_type});

endmodule

/* source/load_store_unit.sv */
// In-order word load/store; 32-word window at data_base, out-of-window loads return 0
`timescale 1ns/1ps

module load_store_unit import exec_pkg::*; (
	input logic clk,
	input logic rst,
	input logic issue_valid,
	input mem_issue_t issue,
	output unit_result_t result
);

	localparam int idx_w = $clog2(dmem_words);
	// Last stage is the result register itself
	localparam int n_stages = mem_latency - 1;

	typedef struct packed {
		logic is_store;
		logic in_range;
		logic [idx_w-1:0] index;
		logic [xlen-1:0] wdata;
		logic [tag_w-1:0] tag;
	} mem_op_t;

	logic [xlen-1:0] addr;
	logic [xlen-1:0] offset;
	mem_op_t issue_op;
	logic [n_stages-1:0] op_valid;
	mem_op_t op_q [n_stages];
	logic [xlen-1:0] dmem [dmem_words];
	mem_op_t last_op;
	logic result_valid;
	logic [tag_w-1:0] result_tag;
	logic [xlen-1:0] result_data;

	assign addr = issue.rs1_data + issue.imm;
	assign offset = addr - data_base;

	assign issue_op = '{is_store: issue.is_store,
		in_range: (offset < xlen'(dmem_words * 4)),
		index: offset[idx_w+1:2], wdata: issue.rs2_data, tag: issue.rd_tag};

	assign last_op = op_q[n_stages-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			op_valid <= '0;
			result_valid <= 1'b0;
			for (int i = 0; i < dmem_words; i++)
				dmem[i] <= '0;
		end else begin
			op_valid[0] <= issue_valid;
			for (int i = 1; i < n_stages; i++)
				op_valid[i] <= op_valid[i-1];
			result_valid <= op_valid[n_stages-1] && !last_op.is_store;
			if (op_valid[n_stages-1] && last_op.is_store && last_op.in_range)
				dmem[last_op.index] <= last_op.wdata;
		end
	end

	always_ff @(posedge clk) begin
		op_q[0] <= issue_op;
		for (int i = 1; i < n_stages; i++)
			op_q[i] <= op_q[i-1];
		result_tag <= last_op.tag;
		result_data <= last_op.in_range ? dmem[last_op.index] : '0;
	end

	assign result = '{valid: result_valid, tag: result_tag, data: result_data,
		branch: 1'b0, branch_taken: 1'b0};

	a_word_aligned: assert property (@(posedge clk) disable iff (rst)
		issue_valid |-> addr[1:0] == 2'b00);

endmodule

/* source/muldiv_pipe.sv */
// Multiply (low word) or unsigned divide by parameter; divide by zero gives all ones
`timescale 1ns/1ps

module muldiv_pipe import exec_pkg::*; #(
	parameter muldiv_op_e op = op_mul
) (
	input logic clk,
	input logic rst,
	input logic issue_valid,
	input md_issue_t issue,
	output unit_result_t result
);

	localparam int lat = (op == op_mul) ? mul_latency : div_latency;

	logic [xlen-1:0] op_value;
	logic [lat-1:0] stage_valid;
	logic [tag_w-1:0] stage_tag [lat];
	logic [xlen-1:0] stage_data [lat];

	always_comb begin
		if (op == op_mul)
			op_value = issue.rs1_data * issue.rs2_data;
		else if (issue.rs2_data == '0)
			op_value = '1;
		else
			op_value = issue.rs1_data / issue.rs2_data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			stage_valid <= '0;
		end else begin
			stage_valid[0] <= issue_valid;
			for (int i = 1; i < lat; i++)
				stage_valid[i] <= stage_valid[i-1];
		end
	end

	// Value computed at issue, then only delayed
	always_ff @(posedge clk) begin
		stage_tag[0] <= issue.rd_tag;
		stage_data[0] <= op_value;
		for (int i = 1; i < lat; i++) begin
			stage_tag[i] <= stage_tag[i-1];
			stage_data[i] <= stage_data[i-1];
		end
	end

	assign result = '{valid: stage_valid[lat-1], tag: stage_tag[lat-1],
		data: stage_data[lat-1], branch: 1'b0, branch_taken: 1'b0};

endmodule

/* sources.f */
source/exec_pkg.sv
source/int_alu_unit.sv
source/muldiv_pipe.sv
source/load_store_unit.sv
source/cdb_arbiter.sv
source/exec_backend_top.sv
testbench/tb_clock_gen.sv
testbench/exec_backend_tb.sv

/* testbench/exec_backend_tb.sv */
// Random and directed issues at one per two cycles; register tags 1..63, branches use tag 0
`timescale 1ns/1ps

module exec_backend_tb import exec_pkg::*; ();

	localparam int n_alu = 40;
	localparam int n_branch = 12;
	localparam int n_md = 30;
	localparam int n_mem = 12;
	localparam int n_mixed = 80;
	localparam int n_issues = n_alu + n_branch + n_md + n_mem + n_mixed;
	localparam int watchdog_cycles = n_issues * 2 + 200;
	localparam int max_wait = 40;

	logic clk;
	logic rst;
	logic int_issue_valid;
	alu_issue_t int_issue;
	logic mul_issue_valid;
	md_issue_t mul_issue;
	logic div_issue_valid;
	md_issue_t div_issue;
	logic mem_issue_valid;
	mem_issue_t mem_issue;
	cdb_t cdb;

	// Scoreboard
	cdb_t exp_by_tag [int];
	int issued_at [int];
	cdb_t branch_q [$];
	int branch_at [$];
	logic [tag_w-1:0] free_tags [$];
	logic [xlen-1:0] ref_mem [dmem_words];
	int cycle_count = 0;

	tb_clock_gen clkgen0 (
		.clk(clk),
		.rst(rst)
	);

	exec_backend_top dut0 (
		.clk(clk),
		.rst(rst),
		.int_issue_valid(int_issue_valid),
		.int_issue(int_issue),
		.mul_issue_valid(mul_issue_valid),
		.mul_issue(mul_issue),
		.div_issue_valid(div_issue_valid),
		.div_issue(div_issue),
		.mem_issue_valid(mem_issue_valid),
		.mem_issue(mem_issue),
		.cdb(cdb)
	);

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	task automatic fail_now(string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "Stopped at first error");
	endtask

	// Expected broadcast of an integer issue, from the RV32I encodings
	function automatic cdb_t alu_expect(alu_issue_t ins);
		cdb_t r;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		r = '0;
		a = ins.rs1_data;
		b = ins.rs2_data;
		if (ins.opcode == branch_type) begin
			r.branch = 1'b1;
			if (ins.funct3 == 3'h0)
				r.branch_taken = (a == b);
			else if (ins.funct3 == 3'h1)
				r.branch_taken = (a != b);
		end else begin
			r.valid = 1'b1;
			r.tag = ins.rd_tag;
			if (ins.opcode == lui_type)
				r.data = b;
			else if (ins.funct3 == 3'h0 && ins.opcode == r_type && ins.funct7 == 7'h20)
				r.data = a - b;
			else if (ins.funct3 == 3'h0 && (ins.opcode == i_type || ins.funct7 == 7'h00))
				r.data = a + b;
			else if (ins.funct3 == 3'h4)
				r.data = a ^ b;
			else if (ins.funct3 == 3'h6)
				r.data = a | b;
			else if (ins.funct3 == 3'h7)
				r.data = a & b;
		end
		return r;
	endfunction

	function automatic cdb_t muldiv_expect(logic is_div, md_issue_t ins);
		cdb_t r;
		r = '0;
		r.valid = 1'b1;
		r.tag = ins.rd_tag;
		if (!is_div)
			r.data = ins.rs1_data * ins.rs2_data;
		else if (ins.rs2_data == '0)
			r.data = '1;
		else
			r.data = ins.rs1_data / ins.rs2_data;
		return r;
	endfunction

	task automatic take_tag(output logic [tag_w-1:0] tag);
		while (free_tags.size() == 0)
			@(posedge clk);
		tag = free_tags.pop_front();
	endtask

	task automatic expect_register(cdb_t exp);
		exp_by_tag[int'(exp.tag)] = exp;
		issued_at[int'(exp.tag)] = cycle_count;
	endtask

	task automatic issue_alu(alu_issue_t ins);
		cdb_t exp;
		@(posedge clk);
		#10;
		exp = alu_expect(ins);
		if (exp.branch) begin
			branch_q.push_back(exp);
			branch_at.push_back(cycle_count);
		end else begin
			expect_register(exp);
		end
		int_issue = ins;
		int_issue_valid = 1'b1;
		@(posedge clk);
		#10;
		int_issue_valid = 1'b0;
	endtask

	task automatic issue_md(logic is_div, md_issue_t ins);
		@(posedge clk);
		#10;
		expect_register(muldiv_expect(is_div, ins));
		if (is_div) begin
			div_issue = ins;
			div_issue_valid = 1'b1;
		end else begin
			mul_issue = ins;
			mul_issue_valid = 1'b1;
		end
		@(posedge clk);
		#10;
		mul_issue_valid = 1'b0;
		div_issue_valid = 1'b0;
	endtask

	// Memory unit is in order, so the model updates at issue
	task automatic issue_mem(mem_issue_t ins);
		logic [xlen-1:0] offset;
		logic in_window;
		int idx;
		cdb_t exp;
		@(posedge clk);
		#10;
		offset = ins.rs1_data + ins.imm - data_base;
		in_window = (offset < 32'(dmem_words * 4));
		idx = int'(offset >> 2);
		if (ins.is_store) begin
			if (in_window)
				ref_mem[idx] = ins.rs2_data;
		end else begin
			exp = '0;
			exp.valid = 1'b1;
			exp.tag = ins.rd_tag;
			exp.data = in_window ? ref_mem[idx] : '0;
			expect_register(exp);
		end
		mem_issue = ins;
		mem_issue_valid = 1'b1;
		@(posedge clk);
		#10;
		mem_issue_valid = 1'b0;
	endtask

	task automatic random_alu();
		alu_issue_t ins;
		logic [tag_w-1:0] tag;
		logic [11:0] imm;
		logic [xlen-1:0] upper;
		int kind;
		ins = '0;
		kind = $urandom_range(0, 9);
		imm = 12'($urandom());
		upper = $urandom();
		ins.rs1_data = $urandom();
		ins.rs2_data = $urandom();
		take_tag(tag);
		ins.rd_tag = tag;
		ins.opcode = (kind < 5) ? r_type : i_type;
		case (kind)
			1: ins.funct7 = 7'h20;
			2: ins.funct3 = 3'h4;
			3: ins.funct3 = 3'h6;
			4: ins.funct3 = 3'h7;
			6: ins.funct3 = 3'h4;
			7: ins.funct3 = 3'h6;
			8: ins.funct3 = 3'h7;
			9: ins.opcode = lui_type;
			default: ins.funct3 = 3'h0;
		endcase
		if (ins.opcode == i_type)
			ins.rs2_data = {{20{imm[11]}}, imm};
		else if (ins.opcode == lui_type)
			ins.rs2_data = {upper[19:0], 12'h000};
		issue_alu(ins);
	endtask

	task automatic random_branch();
		alu_issue_t ins;
		ins = '0;
		ins.opcode = branch_type;
		ins.funct3 = 3'($urandom_range(0, 1));
		ins.rs1_data = $urandom();
		ins.rs2_data = ($urandom_range(0, 1) == 0) ? ins.rs1_data : $urandom();
		issue_alu(ins);
	endtask

	task automatic random_md(logic is_div);
		md_issue_t ins;
		logic [tag_w-1:0] tag;
		int pick;
		pick = $urandom_range(0, 3);
		take_tag(tag);
		ins.rd_tag = tag;
		ins.rs1_data = $urandom();
		if (pick == 0)
			ins.rs2_data = '0;
		else if (pick == 1)
			ins.rs2_data = 32'($urandom_range(1, 255));
		else
			ins.rs2_data = $urandom();
		issue_md(is_div, ins);
	endtask

	task automatic mem_access(logic is_store, logic [xlen-1:0] addr, logic [xlen-1:0] wdata);
		mem_issue_t ins;
		logic [tag_w-1:0] tag;
		logic [xlen-1:0] split;
		tag = '0;
		if (!is_store)
			take_tag(tag);
		// Address split between base register and immediate
		split = 32'(4 * $urandom_range(0, 7));
		ins.is_store = is_store;
		ins.rs1_data = addr - split;
		ins.imm = split;
		ins.rs2_data = wdata;
		ins.rd_tag = tag;
		issue_mem(ins);
	endtask

	task automatic random_mem();
		int w;
		w = $urandom_range(0, dmem_words + 3);
		mem_access(1'($urandom_range(0, 1)), data_base + 32'(w * 4), $urandom());
	endtask

	// Compare on the falling edge, where the registered CDB is settled
	always @(negedge clk) begin : compare
		int t;
		cdb_t exp;
		if (!rst) begin
			assert (!(cdb.valid && cdb.branch))
				else fail_now("CDB carried a register result and a branch outcome at once");
			if (cdb.valid) begin
				t = int'(cdb.tag);
				assert (exp_by_tag.exists(t))
					else fail_now($sformatf("Broadcast of unexpected tag %0d at %0t", t, $time));
				exp = exp_by_tag[t];
				assert (cdb == exp)
					else fail_now($sformatf("Mismatch at %0t: tag %0d got %h, expected %h",
						$time, t, cdb, exp));
				exp_by_tag.delete(t);
				issued_at.delete(t);
				free_tags.push_back(cdb.tag);
			end
			if (cdb.branch) begin
				assert (branch_q.size() != 0)
					else fail_now("Extra branch broadcast with no branch pending");
				exp = branch_q.pop_front();
				void'(branch_at.pop_front());
				assert (cdb == exp)
					else fail_now($sformatf("Mismatch at %0t: branch got %h, expected %h",
						$time, cdb, exp));
			end
			foreach (issued_at[k])
				assert (cycle_count - issued_at[k] <= max_wait)
					else fail_now($sformatf("Tag %0d not broadcast within %0d cycles of issue",
						k, max_wait));
			if (branch_at.size() != 0)
				assert (cycle_count - branch_at[0] <= max_wait)
					else fail_now("Branch outcome not broadcast within 40 cycles of issue");
		end
	end

	initial begin : watchdog
		repeat (watchdog_cycles) @(posedge clk);
		fail_now($sformatf("Run did not finish within %0d cycles", watchdog_cycles));
	end

	initial begin
		int w;
		int drain;
		logic [xlen-1:0] addr;
		int_issue_valid = 1'b0;
		int_issue = '0;
		mul_issue_valid = 1'b0;
		mul_issue = '0;
		div_issue_valid = 1'b0;
		div_issue = '0;
		mem_issue_valid = 1'b0;
		mem_issue = '0;
		void'($urandom(32'hec46_2b60));
		for (int t = 1; t < 64; t++)
			free_tags.push_back(tag_w'(t));
		foreach (ref_mem[i])
			ref_mem[i] = '0;
		while (rst !== 1'b0)
			@(posedge clk);

		// Idle bus after reset
		repeat (20) begin
			@(negedge clk);
			assert (!cdb.valid && !cdb.branch)
				else fail_now("CDB active after reset with nothing issued");
		end

		repeat (n_alu) random_alu();
		repeat (n_branch) random_branch();
		for (int i = 0; i < n_md; i++)
			random_md(1'(i % 2));

		for (int i = 0; i < 4; i++) begin
			w = $urandom_range(0, dmem_words - 1);
			addr = data_base + 32'(w * 4);
			mem_access(1'b1, addr, $urandom());
			mem_access(1'b0, addr, '0);
		end
		// Just past the window, must leave word 0 alone
		mem_access(1'b1, data_base + 32'(dmem_words * 4), 32'hdead_beef);
		mem_access(1'b0, data_base, '0);
		mem_access(1'b0, data_base - 32'h4, '0);
		mem_access(1'b0, data_base + 32'h400, '0);

		for (int i = 0; i < n_mixed; i++) begin
			case ($urandom_range(0, 4))
				0: random_alu();
				1: random_branch();
				2: random_md(1'b0);
				3: random_md(1'b1);
				default: random_mem();
			endcase
		end

		// Every result is due within max_wait cycles of its issue
		drain = 0;
		while ((exp_by_tag.size() != 0 || branch_q.size() != 0) && drain < max_wait) begin
			@(posedge clk);
			drain++;
		end
		repeat (10) @(negedge clk);
		if (exp_by_tag.size() == 0 && branch_q.size() == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			fail_now("Expected results still pending at the end of the run");
		end
	end

endmodule

/* testbench/tb_clock_gen.sv */
// Free-running 100 ns clock; synchronous reset held high for the first 10 rising edges
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Released just after the tenth edge, like the other inputs
	initial begin
		rst = 1'b1;
		repeat (10) @(posedge clk);
		#10;
		rst = 1'b0;
	end

endmodule
